// ==== hdl/microbio_pkg.sv ====
//--------------------------------------------------------------------
// Shared constants of the LED sequencer: instruction format, opcodes,
// FSM encoding and the WAIT timer period
// wait_period is short for simulation; raise it for a board build
//--------------------------------------------------------------------
`default_nettype none

package microbio_pkg;

  //--------------------------------------------------------------------
  // Program memory geometry
  //--------------------------------------------------------------------
  // Address width of the program counter and memory
  localparam int addr_w = 6;
  // One instruction word
  localparam int data_w = 8;
  localparam int mem_depth = 64;

  //--------------------------------------------------------------------
  // Instruction format: op in the top 2 bits, data field below
  //--------------------------------------------------------------------
  localparam int op_w = 2;

  // Pause until the next timer tick
  localparam logic [op_w-1:0] op_wait = 2'b00;
  // Stop for good, raises stop
  localparam logic [op_w-1:0] op_halt = 2'b01;
  // Load the low data bits into the LED register
  localparam logic [op_w-1:0] op_leds = 2'b10;
  // Jump to the data field address
  localparam logic [op_w-1:0] op_jp = 2'b11;

  // LED register width, taken from the low data bits
  localparam int led_w = 4;

  //--------------------------------------------------------------------
  // WAIT timer
  //--------------------------------------------------------------------
  // Clock cycles between ticks
  localparam int wait_period = 16;
  localparam int tmr_w = $clog2(wait_period);

  // Control unit states
  typedef enum logic [1:0] {
    st_init  = 2'd0,
    st_fetch = 2'd1,
    st_exec  = 2'd2
  } state_t;

endpackage

`default_nettype wire

// ==== hdl/prog_mem.sv ====
//--------------------------------------------------------------------
// 64x8 program memory, APB slave for load and readback, plus a fetch
// port with one cycle of read latency. No APB wait states
// Writes are refused with pslverr while run is high
//--------------------------------------------------------------------
`default_nettype none

module prog_mem (
  input  wire                               clk,
  input  wire                               rstn,
  input  wire                               run,
  input  wire                               psel,
  input  wire                               penable,
  input  wire                               pwrite,
  input  wire  [microbio_pkg::addr_w-1:0]   paddr,
  input  wire  [microbio_pkg::data_w-1:0]   pwdata,
  output logic [microbio_pkg::data_w-1:0]   prdata,
  output logic                              pready,
  output logic                              pslverr,
  input  wire  [microbio_pkg::addr_w-1:0]   fetch_addr,
  output logic [microbio_pkg::data_w-1:0]   fetch_data
);
  import microbio_pkg::*;

  logic [data_w-1:0] mem [mem_depth];
  logic              setup;
  logic              access;

  // APB phases
  assign setup  = psel && !penable;
  assign access = psel && penable;

  // Every transfer completes in its first access cycle
  assign pready = 1'b1;

  // Write decision taken in the setup cycle, error shown in access
  always_ff @(posedge clk) begin
    if (!rstn) begin
      pslverr <= 1'b0;
    end else begin
      pslverr <= setup && pwrite && run;
    end
  end

  // Array write on the access cycle unless refused
  always_ff @(posedge clk) begin
    if (access && pwrite && !pslverr) begin
      mem[paddr] <= pwdata;
    end
  end

  // APB read started in setup, data valid during access
  always_ff @(posedge clk) begin
    if (setup) begin
      prdata <= mem[paddr];
    end
  end

  // Fetch port, registered read
  always_ff @(posedge clk) begin
    fetch_data <= mem[fetch_addr];
  end

  // Host must keep psel high through the access phase
  a_penable_psel: assert property (@(posedge clk) disable iff (!rstn)
    penable |-> psel);

  // Error only reported in the access cycle of a transfer
  a_slverr_access: assert property (@(posedge clk) disable iff (!rstn)
    pslverr |-> psel && penable && pwrite);

endmodule

`default_nettype wire

// ==== hdl/wait_timer.sv ====
//--------------------------------------------------------------------
// Free-running tick generator for the WAIT instruction
// tick is high for one cycle every wait_period cycles
//--------------------------------------------------------------------
`default_nettype none

module wait_timer (
  input  wire  clk,
  input  wire  rstn,
  output logic tick
);
  import microbio_pkg::*;

  logic [tmr_w-1:0] cnt;

  // Count 0 .. wait_period-1, pulse on wrap
  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (cnt == tmr_w'(wait_period - 1)) begin
      cnt  <= '0;
      tick <= 1'b1;
    end else begin
      cnt  <= cnt + 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/microbio_core.sv ====
//--------------------------------------------------------------------
// Fetch/execute control unit: pc, instruction register, LEDs, stop
// Expects fetch_data one cycle after fetch_addr
// After HALT the core stays stopped until rstn, even if run toggles
//--------------------------------------------------------------------
`default_nettype none

module microbio_core (
  input  wire                               clk,
  input  wire                               rstn,
  input  wire                               run,
  output logic [microbio_pkg::addr_w-1:0]   fetch_addr,
  input  wire  [microbio_pkg::data_w-1:0]   fetch_data,
  input  wire                               tick,
  output logic [microbio_pkg::led_w-1:0]    leds,
  output logic                              stop
);
  import microbio_pkg::*;

  state_t            state;
  state_t            state_nxt;
  logic [addr_w-1:0] pc;
  logic [data_w-1:0] ir;
  logic [op_w-1:0]   op;
  logic [addr_w-1:0] dat;

  // Control strobes from the FSM
  logic pc_inc;
  logic pc_load;
  logic ir_load;
  logic leds_load;
  logic halt;

  // Instruction fields
  assign op  = ir[data_w-1 -: op_w];
  assign dat = ir[addr_w-1:0];

  // pc addresses memory directly
  assign fetch_addr = pc;

  //--------------------------------------------------------------------
  // State register
  //--------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= st_init;
    end else begin
      state <= state_nxt;
    end
  end

  //--------------------------------------------------------------------
  // Next state and strobes
  //--------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    pc_inc    = 1'b0;
    pc_load   = 1'b0;
    ir_load   = 1'b0;
    leds_load = 1'b0;
    halt      = 1'b0;
    case (state)
      // Idle, or one cycle for memory to see pc
      st_init: begin
        if (run && !stop) begin
          state_nxt = st_fetch;
        end
      end
      // Capture the word and advance pc
      st_fetch: begin
        ir_load   = 1'b1;
        pc_inc    = 1'b1;
        state_nxt = st_exec;
      end
      st_exec: begin
        case (op)
          op_wait: begin
            // Hold until the timer ticks
            if (tick) begin
              state_nxt = st_fetch;
            end
          end
          op_halt: begin
            // Park here for good
            halt = 1'b1;
          end
          op_leds: begin
            leds_load = 1'b1;
            state_nxt = st_fetch;
          end
          default: begin
            // JP, extra init cycle so the new pc reaches memory
            pc_load   = 1'b1;
            state_nxt = st_init;
          end
        endcase
      end
      default: begin
        state_nxt = st_init;
      end
    endcase
    // Dropping run aborts the program, no side effects
    if (!run) begin
      state_nxt = st_init;
      pc_inc    = 1'b0;
      pc_load   = 1'b0;
      ir_load   = 1'b0;
      leds_load = 1'b0;
      halt      = 1'b0;
    end
  end

  //--------------------------------------------------------------------
  // Datapath registers
  //--------------------------------------------------------------------
  // Program counter, back to 0 whenever run is low
  always_ff @(posedge clk) begin
    if (!rstn || !run) begin
      pc <= '0;
    end else if (pc_load) begin
      pc <= dat;
    end else if (pc_inc) begin
      pc <= pc + 1'b1;
    end
  end

  // Instruction register
  always_ff @(posedge clk) begin
    if (ir_load) begin
      ir <= fetch_data;
    end
  end

  // LEDs and stop, only rstn clears them
  always_ff @(posedge clk) begin
    if (!rstn) begin
      leds <= '0;
      stop <= 1'b0;
    end else begin
      if (leds_load) begin
        leds <= dat[led_w-1:0];
      end
      if (halt) begin
        stop <= 1'b1;
      end
    end
  end

  // Stop is sticky until reset
  a_stop_sticky: assert property (@(posedge clk) disable iff (!rstn)
    stop |=> stop);

  // A halted core no longer touches the LEDs
  a_leds_frozen: assert property (@(posedge clk) disable iff (!rstn)
    stop |=> $stable(leds));

endmodule

`default_nettype wire

// ==== hdl/microbio_top.sv ====
//--------------------------------------------------------------------
// LED sequencer top: program memory, WAIT timer and control unit
// Load the program over APB with run low, then raise run
//--------------------------------------------------------------------
`default_nettype none

module microbio_top (
  input  wire                               clk,
  input  wire                               rstn,
  input  wire                               run,
  input  wire                               psel,
  input  wire                               penable,
  input  wire                               pwrite,
  input  wire  [microbio_pkg::addr_w-1:0]   paddr,
  input  wire  [microbio_pkg::data_w-1:0]   pwdata,
  output logic [microbio_pkg::data_w-1:0]   prdata,
  output logic                              pready,
  output logic                              pslverr,
  output logic [microbio_pkg::led_w-1:0]    leds,
  output logic                              stop
);
  import microbio_pkg::*;

  // Core to memory fetch path
  logic [addr_w-1:0] fetch_addr;
  logic [data_w-1:0] fetch_data;
  // WAIT pacing
  logic              tick;

  prog_mem i_mem (
    .clk        (clk),
    .rstn       (rstn),
    .run        (run),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data)
  );

  wait_timer i_timer (
    .clk  (clk),
    .rstn (rstn),
    .tick (tick)
  );

  microbio_core i_core (
    .clk        (clk),
    .rstn       (rstn),
    .run        (run),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data),
    .tick       (tick),
    .leds       (leds),
    .stop       (stop)
  );

endmodule

`default_nettype wire

// ==== include/tb_util.svh ====
//--------------------------------------------------------------------
// Testbench helpers: LCG, check, APB write and read
// Include inside the testbench module after clk, psel, penable,
// pwrite, paddr, pwdata, prdata and pslverr are declared
//--------------------------------------------------------------------
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// Next LCG state, 32-bit numerical recipe constants
function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// Compare one value, stop on the first mismatch
task automatic check(input logic [31:0] got, input logic [31:0] want,
                     input string what);
  if (got !== want) begin
    $display("ERR at time %0t: %s: got %0h, expected %0h", $time, what, got, want);
    $display("*** TEST FAILED ***");
    $fatal(1, "check failed");
  end
endtask

// One APB write, inputs change on the falling edge
task automatic apb_write(input logic [microbio_pkg::addr_w-1:0] addr,
                         input logic [microbio_pkg::data_w-1:0] data,
                         output logic err);
  @(negedge clk);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = 1'b1;
  paddr   = addr;
  pwdata  = data;
  @(negedge clk);
  // Access cycle, error flag already registered
  penable = 1'b1;
  err     = pslverr;
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

// One APB read, data sampled inside the access cycle
task automatic apb_read(input logic [microbio_pkg::addr_w-1:0] addr,
                        output logic [microbio_pkg::data_w-1:0] data);
  @(negedge clk);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = 1'b0;
  paddr   = addr;
  @(negedge clk);
  penable = 1'b1;
  data    = prdata;
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
endtask

`endif

// ==== bench/microbio_tb.sv ====
//--------------------------------------------------------------------
// Random programs of WAIT, LEDS and forward JP, ending in HALT
// LED changes are compared with an instruction-level model
// Memory keeps its content across rstn, so a program can be rerun
//--------------------------------------------------------------------
`default_nettype none

module microbio_tb;
  import microbio_pkg::*;

  localparam int num_progs = 6;
  localparam int stop_limit = 4000;

  logic              clk;
  logic              rstn;
  logic              run;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [addr_w-1:0] paddr;
  logic [data_w-1:0] pwdata;
  logic [data_w-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic [led_w-1:0]  leds;
  logic              stop;

  // Program image and model results
  logic [data_w-1:0] prog [mem_depth];
  int                prog_len;
  logic [led_w-1:0]  exp_seq[$];
  logic [led_w-1:0]  exp_final;
  // Monitor record of LED changes
  logic [led_w-1:0]  seen[$];
  logic [led_w-1:0]  prev_leds;
  logic [31:0]       rng;

  `include "tb_util.svh"

  microbio_top i_dut (
    .clk     (clk),
    .rstn    (rstn),
    .run     (run),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .leds    (leds),
    .stop    (stop)
  );

  always #4 clk = ~clk;

  // Sample on the falling edge where leds is stable, each change once
  always @(negedge clk) begin
    if (leds !== prev_leds) begin
      seen.push_back(leds);
    end
    prev_leds = leds;
  end

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng = lcg_next(rng);
    // Low LCG bits are weak
    return rng >> 8;
  endfunction

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "timeout");
  endtask

  // rstn low for 3 cycles, run dropped, monitor cleared
  task automatic apply_reset();
    @(negedge clk);
    rstn = 1'b0;
    run  = 1'b0;
    repeat (3) @(negedge clk);
    seen.delete();
    rstn = 1'b1;
  endtask

  // Random body, JP only forward, HALT on the last word
  task automatic build_program();
    logic [31:0] r;
    int          tgt;
    r = next_rand();
    prog_len = 8 + int'(r % 32'd56);
    for (int i = 0; i < prog_len - 1; i++) begin
      r = next_rand();
      case (r % 32'd3)
        32'd0: prog[i] = {op_wait, r[13:8]};
        32'd1: prog[i] = {op_leds, r[13:8]};
        default: begin
          tgt = i + 1 + int'((r >> 8) % 32'(prog_len - 1 - i));
          prog[i] = {op_jp, addr_w'(tgt)};
        end
      endcase
    end
    prog[prog_len-1] = {op_halt, 6'd0};
  endtask

  // Instruction-level walk, repeated loads of the same value dropped
  task automatic run_model();
    int                pc;
    logic [op_w-1:0]   op;
    logic [led_w-1:0]  cur;
    exp_seq.delete();
    pc  = 0;
    cur = '0;
    for (int steps = 0; steps < 1000; steps++) begin
      op = prog[pc][data_w-1 -: op_w];
      if (op == op_halt) begin
        break;
      end else if (op == op_jp) begin
        pc = int'(prog[pc][addr_w-1:0]);
      end else begin
        if (op == op_leds && prog[pc][led_w-1:0] != cur) begin
          cur = prog[pc][led_w-1:0];
          exp_seq.push_back(cur);
        end
        pc++;
      end
    end
    exp_final = cur;
  endtask

  task automatic load_program();
    logic              err;
    logic [data_w-1:0] rd;
    for (int i = 0; i < prog_len; i++) begin
      apb_write(addr_w'(i), prog[i], err);
      check(32'(err), 32'd0, "pslverr on load");
      check(32'(pready), 32'd1, "pready");
    end
    for (int i = 0; i < prog_len; i++) begin
      apb_read(addr_w'(i), rd);
      check(32'(rd), 32'(prog[i]), $sformatf("readback of word %0d", i));
    end
  endtask

  task automatic wait_stop();
    int cyc;
    cyc = 0;
    while (!stop && cyc < stop_limit) begin
      @(negedge clk);
      cyc++;
    end
    if (!stop) begin
      report_timeout("stop did not rise after the program was started");
    end
  endtask

  // Run, wait for HALT, then compare LED history and final state
  task automatic start_and_check();
    @(negedge clk);
    run = 1'b1;
    wait_stop();
    check(32'(seen.size()), 32'(exp_seq.size()), "number of LED changes");
    for (int i = 0; i < seen.size(); i++) begin
      check(32'(seen[i]), 32'(exp_seq[i]), $sformatf("LED change %0d", i));
    end
    check(32'(leds), 32'(exp_final), "leds at halt");
    // Halted core must hold its outputs
    for (int c = 0; c < 50; c++) begin
      @(negedge clk);
      check(32'(leds), 32'(exp_final), "leds after halt");
      check(32'(stop), 32'd1, "stop after halt");
    end
  endtask

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------
  initial begin
    logic              err;
    logic [data_w-1:0] rd;
    int                cyc;
    clk     = 1'b0;
    rstn    = 1'b0;
    run     = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rng     = 32'hc9d0_4a56;

    for (int p = 0; p < num_progs; p++) begin
      apply_reset();
      build_program();
      run_model();
      load_program();
      start_and_check();
    end

    // Write while halted with run high is refused
    apb_write('0, ~prog[0], err);
    check(32'(err), 32'd1, "pslverr on write with run high");
    @(negedge clk);
    run = 1'b0;
    apb_read('0, rd);
    check(32'(rd), 32'(prog[0]), "word 0 after refused write");

    // Interrupt the same program by reset once it has lit an LED
    apply_reset();
    @(negedge clk);
    run = 1'b1;
    cyc = 0;
    while (leds == '0 && !stop && cyc < stop_limit) begin
      @(negedge clk);
      cyc++;
    end
    if (leds == '0 && !stop) begin
      report_timeout("program neither lit an LED nor halted");
    end
    apply_reset();
    check(32'(leds), 32'd0, "leds after reset");
    check(32'(stop), 32'd0, "stop after reset");
    start_and_check();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
hdl/microbio_pkg.sv
hdl/prog_mem.sv
hdl/wait_timer.sv
hdl/microbio_core.sv
hdl/microbio_top.sv
bench/microbio_tb.sv

// ==== Makefile ====
# Verilator build and run of the LED sequencer testbench

TOP = microbio_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -F -q "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
